//--- verilog/magnitude_pkg.sv
package magnitude_pkg;

	// width of one gradient component, signed two's complement
	localparam int vec_w = 9;

	// sum of squares width, the largest sum 2*256*256 needs only 18 bits
	localparam int in_prec_default = 20;

	// root width, one root bit is produced per pipeline stage
	localparam int out_prec_default = 10;

	// one gradient sample as it enters the unit
	typedef struct packed {
		logic                    valid;
		logic signed [vec_w-1:0] x;
		logic signed [vec_w-1:0] y;
	} gradient_sample_t;

	// dominant direction of a gradient, in quarter turns from east
	typedef enum logic [1:0] {
		dir_east  = 2'd0,
		dir_north = 2'd1,
		dir_west  = 2'd2,
		dir_south = 2'd3
	} direction_t;

	// one registered result of the unit
	// edge_flag is set when the magnitude reaches the threshold level
	typedef struct packed {
		logic                        valid;
		logic [out_prec_default-1:0] magnitude;
		logic                        edge_flag;
		direction_t                  direction;
	} edge_result_t;

endpackage

//--- verilog/sum_of_squares.sv
`timescale 1ns/1ps

module sum_of_squares #(
	parameter int IN_PREC = 20
) (
	input  logic                                  clk,
	input  logic                                  aclr,
	input  logic                                  clken,
	input  logic signed [magnitude_pkg::vec_w-1:0] x,
	input  logic signed [magnitude_pkg::vec_w-1:0] y,
	output logic [IN_PREC-1:0]                    sum
);

	// a square of a 9-bit signed value fits an 18-bit product
	localparam int PROD_W = 2 * magnitude_pkg::vec_w;

	logic signed [PROD_W-1:0] x_sq;
	logic signed [PROD_W-1:0] y_sq;
	logic [IN_PREC-1:0]       sum_next;

	// both operands are signed, so the multiply is a signed one
	// the squares are never negative, even for the most negative input
	assign x_sq = x * x;
	assign y_sq = y * y;

	// the products are zero extended to the sum width before the add
	// the add itself cannot overflow for any IN_PREC of 18 or more
	assign sum_next = IN_PREC'($unsigned(x_sq)) + IN_PREC'($unsigned(y_sq));

	// one register stage, it only advances on enabled cycles
	always_ff @(posedge clk or posedge aclr)
	begin
		if (aclr)
		begin
			sum <= '0;
		end
		else if (clken)
		begin
			sum <= sum_next;
		end
	end

endmodule

//--- verilog/root_pipeline.sv
`timescale 1ns/1ps

module root_pipeline #(
	parameter int IN_PREC  = 20,
	parameter int OUT_PREC = 10
) (
	input  logic                clk,
	input  logic                aclr,
	input  logic                clken,
	input  logic [IN_PREC-1:0]  rad,
	output logic [OUT_PREC-1:0] root
);

	// each root bit consumes two radicand bits
	localparam int RAD_W = 2 * OUT_PREC;

	// the signed remainder needs two bits more than the root
	localparam int REM_W = OUT_PREC + 2;

	// the radicand is fitted to twice the root width
	// any bits above that would give root bits beyond OUT_PREC anyway
	logic [RAD_W-1:0] rad_fit;

	assign rad_fit = RAD_W'(rad);

	for (genvar s = 0; s < OUT_PREC; s++)
	begin : stage
		logic signed [REM_W-1:0] rem_in;
		logic [OUT_PREC-1:0]     root_in;
		logic [RAD_W-1:0]        rad_in;
		logic signed [REM_W-1:0] rem_shift;
		logic signed [REM_W-1:0] rem_next;
		logic [OUT_PREC-1:0]     root_next;
		logic signed [REM_W-1:0] rem_r;
		logic [OUT_PREC-1:0]     root_r;

		// the first stage starts from an empty remainder and root
		if (s == 0)
		begin : first
			assign rem_in  = '0;
			assign root_in = '0;
			assign rad_in  = rad_fit;
		end
		else
		begin : chain
			assign rem_in  = stage[s-1].rem_r;
			assign root_in = stage[s-1].root_r;
			assign rad_in  = stage[s-1].carry.rad_r;
		end

		// bring down the next two radicand bits, most significant first
		assign rem_shift = $signed({rem_in[REM_W-3:0], rad_in[RAD_W-1 -: 2]});

		// non-restoring step: a positive remainder tries a subtraction of 4q+1
		// while a negative one is corrected by adding 4q+3 instead
		always_comb
		begin
			if (rem_in[REM_W-1])
			begin
				rem_next = rem_shift + $signed({root_in, 2'b11});
			end
			else
			begin
				rem_next = rem_shift - $signed({root_in, 2'b01});
			end
		end

		// the new root bit is one when the remainder stayed non-negative
		assign root_next = {root_in[OUT_PREC-2:0], ~rem_next[REM_W-1]};

		always_ff @(posedge clk or posedge aclr)
		begin
			if (aclr)
			begin
				rem_r  <= '0;
				root_r <= '0;
			end
			else if (clken)
			begin
				rem_r  <= rem_next;
				root_r <= root_next;
			end
		end

		// unused radicand bits only travel on while a later stage needs them
		if (s < OUT_PREC - 1)
		begin : carry
			logic [RAD_W-1:0] rad_r;

			always_ff @(posedge clk or posedge aclr)
			begin
				if (aclr)
				begin
					rad_r <= '0;
				end
				else if (clken)
				begin
					rad_r <= rad_in << 2;
				end
			end
		end
	end

	// after the last stage the root holds floor(sqrt(rad))
	assign root = stage[OUT_PREC-1].root_r;

endmodule

//--- verilog/magnitude.sv
`timescale 1ns/1ps

module magnitude #(
	parameter int IN_PREC  = 20,
	parameter int OUT_PREC = 10
) (
	input  logic                            clk,
	input  logic                            aclr,
	input  logic                            clken,
	input  magnitude_pkg::gradient_sample_t sample,
	output logic [OUT_PREC-1:0]             mag,
	output logic                            mag_valid
);

	// sum, squares_pipe, the root stages and the output register
	localparam int LATENCY = OUT_PREC + 3;

	logic [IN_PREC-1:0]  squares;
	logic [IN_PREC-1:0]  squares_pipe;
	logic [OUT_PREC-1:0] magnitude_w;
	logic [OUT_PREC-1:0] magnitude_pipe;
	logic [LATENCY-1:0]  valid_sr;

	sum_of_squares #(
		.IN_PREC(IN_PREC)
	) squares_inst (
		.clk  (clk),
		.aclr (aclr),
		.clken(clken),
		.x    (sample.x),
		.y    (sample.y),
		.sum  (squares)
	);

	root_pipeline #(
		.IN_PREC (IN_PREC),
		.OUT_PREC(OUT_PREC)
	) root_inst (
		.clk  (clk),
		.aclr (aclr),
		.clken(clken),
		.rad  (squares_pipe),
		.root (magnitude_w)
	);

	// register ahead of the root and register behind it
	// the valid strobe shifts alongside so it marks the matching magnitude
	always_ff @(posedge clk or posedge aclr)
	begin
		if (aclr)
		begin
			squares_pipe   <= '0;
			magnitude_pipe <= '0;
			valid_sr       <= '0;
		end
		else if (clken)
		begin
			squares_pipe   <= squares;
			magnitude_pipe <= magnitude_w;
			valid_sr       <= {valid_sr[LATENCY-2:0], sample.valid};
		end
	end

	assign mag       = magnitude_pipe;
	assign mag_valid = valid_sr[LATENCY-1];

endmodule

//--- verilog/edge_classifier.sv
`timescale 1ns/1ps

module edge_classifier #(
	parameter int OUT_PREC = 10
) (
	input  logic                            clk,
	input  logic                            aclr,
	input  logic                            clken,
	input  magnitude_pkg::gradient_sample_t sample,
	input  logic [OUT_PREC-1:0]             mag,
	input  logic                            mag_valid,
	input  logic [OUT_PREC-1:0]             threshold,
	output magnitude_pkg::edge_result_t     result
);

	// the direction must wait as long as the magnitude path takes
	localparam int DEPTH = OUT_PREC + 3;

	// absolute values need no extra bit, since 256 still fits unsigned
	logic [magnitude_pkg::vec_w-1:0] abs_x;
	logic [magnitude_pkg::vec_w-1:0] abs_y;
	magnitude_pkg::direction_t       dir_in;
	magnitude_pkg::direction_t       dir_pipe [0:DEPTH-1];

	assign abs_x = sample.x[magnitude_pkg::vec_w-1] ? -sample.x : sample.x;
	assign abs_y = sample.y[magnitude_pkg::vec_w-1] ? -sample.y : sample.y;

	// the larger component wins, ties go to the horizontal axis
	always_comb
	begin
		if (abs_x >= abs_y)
		begin
			dir_in = sample.x[magnitude_pkg::vec_w-1] ? magnitude_pkg::dir_west
			                                          : magnitude_pkg::dir_east;
		end
		else
		begin
			dir_in = sample.y[magnitude_pkg::vec_w-1] ? magnitude_pkg::dir_south
			                                          : magnitude_pkg::dir_north;
		end
	end

	// delay line for the direction code, it holds with the rest of the pipe
	always_ff @(posedge clk or posedge aclr)
	begin
		if (aclr)
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				dir_pipe[i] <= magnitude_pkg::dir_east;
			end
		end
		else if (clken)
		begin
			dir_pipe[0] <= dir_in;
			for (int i = 1; i < DEPTH; i++)
			begin
				dir_pipe[i] <= dir_pipe[i-1];
			end
		end
	end

	// output register, threshold is sampled here as a plain level
	// an edge is only reported together with a valid magnitude
	always_ff @(posedge clk or posedge aclr)
	begin
		if (aclr)
		begin
			result <= '0;
		end
		else if (clken)
		begin
			result.valid     <= mag_valid;
			result.magnitude <= mag;
			result.edge_flag <= mag_valid && (mag >= threshold);
			result.direction <= dir_pipe[DEPTH-1];
		end
	end

endmodule

//--- verilog/gradient_magnitude_top.sv
`timescale 1ns/1ps

module gradient_magnitude_top #(
	parameter int IN_PREC  = magnitude_pkg::in_prec_default,
	parameter int OUT_PREC = magnitude_pkg::out_prec_default
) (
	input  logic                            clk,
	input  logic                            aclr,
	input  logic                            clken,
	input  magnitude_pkg::gradient_sample_t sample,
	input  logic [OUT_PREC-1:0]             threshold,
	output magnitude_pkg::edge_result_t     result
);

	// magnitude of the sample, aligned with its valid strobe
	logic [OUT_PREC-1:0] mag_out;
	logic                mag_valid;

	magnitude #(
		.IN_PREC (IN_PREC),
		.OUT_PREC(OUT_PREC)
	) magnitude_inst (
		.clk      (clk),
		.aclr     (aclr),
		.clken    (clken),
		.sample   (sample),
		.mag      (mag_out),
		.mag_valid(mag_valid)
	);

	// the classifier sees the raw sample to find the direction early
	edge_classifier #(
		.OUT_PREC(OUT_PREC)
	) classifier_inst (
		.clk      (clk),
		.aclr     (aclr),
		.clken    (clken),
		.sample   (sample),
		.mag      (mag_out),
		.mag_valid(mag_valid),
		.threshold(threshold),
		.result   (result)
	);

endmodule

//--- verif/gradient_magnitude_properties.sv
`timescale 1ns/1ps

module gradient_magnitude_properties (
	input logic                            clk,
	input logic                            aclr,
	input logic                            clken,
	input magnitude_pkg::gradient_sample_t sample,
	input magnitude_pkg::edge_result_t     result
);

	// enabled cycles from a sample to its result, the sample edge included
	localparam int latency = magnitude_pkg::out_prec_default + 4;

	// input valid strobes shifted on enabled cycles only
	logic [latency-1:0] valid_track;

	always_ff @(posedge clk or posedge aclr)
	begin
		if (aclr)
		begin
			valid_track <= '0;
		end
		else if (clken)
		begin
			valid_track <= {valid_track[latency-2:0], sample.valid};
		end
	end

	reset_clears: assert property (@(posedge clk) aclr |-> result == '0)
		else $error("result is not zero during reset");

	stall_holds: assert property (@(posedge clk) disable iff (aclr) !clken |=> $stable(result))
		else $error("result changed on a cycle without clken");

	// an edge never appears on an idle output slot
	edge_needs_valid: assert property (@(posedge clk) disable iff (aclr)
		result.edge_flag |-> result.valid)
		else $error("edge flag is set on a result without valid");

	valid_latency: assert property (@(posedge clk) disable iff (aclr)
		result.valid == valid_track[latency-1])
		else $error("result valid does not follow the input valid by 14 enabled cycles");

endmodule

bind gradient_magnitude_top gradient_magnitude_properties properties_inst (
	.clk   (clk),
	.aclr  (aclr),
	.clken (clken),
	.sample(sample),
	.result(result)
);

//--- verif/gradient_magnitude_tb.sv
`timescale 1ns/1ps

module gradient_magnitude_tb;

	localparam int vec_w = magnitude_pkg::vec_w;
	localparam int out_prec = magnitude_pkg::out_prec_default;

	// enabled cycles from a sample to its result, the sample edge included
	localparam int latency = out_prec + 4;

	localparam int stream_n = 500;
	localparam int stall_n = 300;
	localparam int gap_n = 300;
	localparam int sweep_n = 64;

	// reset, corners, the three random phases, three sweeps and a drain after each phase
	// stalled phases need about one and a half cycles per sample
	localparam int test_cycles = 16 + 40 + stream_n + (3 * stall_n) / 2 + gap_n
		+ 3 * sweep_n + 8 * (latency + 4);
	localparam int max_cycles = 2 * test_cycles;

	logic                            clk;
	logic                            aclr;
	logic                            clken;
	magnitude_pkg::gradient_sample_t sample;
	logic [out_prec-1:0]             threshold;
	magnitude_pkg::edge_result_t     result;

	// expected results in input order, with the enabled edge count before each sample
	magnitude_pkg::edge_result_t expected_q [$];
	int                          stamp_q [$];

	logic [31:0]             rng = 32'd49;
	int                      en_count = 0;
	int                      cycle_count = 0;
	logic                    advanced = 1'b0;
	int                      value_errors = 0;
	int                      order_errors = 0;
	int                      timing_errors = 0;
	logic signed [vec_w-1:0] sweep_x [sweep_n];
	logic signed [vec_w-1:0] sweep_y [sweep_n];

	gradient_magnitude_top #(
		.IN_PREC (magnitude_pkg::in_prec_default),
		.OUT_PREC(out_prec)
	) DUT (
		.clk      (clk),
		.aclr     (aclr),
		.clken    (clken),
		.sample   (sample),
		.threshold(threshold),
		.result   (result)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#2 clk = ~clk;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] t;
		t = s;
		t = t ^ (t << 13);
		t = t ^ (t >> 17);
		t = t ^ (t << 5);
		return t;
	endfunction

	// the largest r whose square does not exceed s, found by plain counting
	function automatic int int_sqrt(input int s);
		int r;
		r = 0;
		while ((r + 1) * (r + 1) <= s)
		begin
			r++;
		end
		return r;
	endfunction

	function automatic magnitude_pkg::edge_result_t expected_result(input int x, input int y,
		input int level);
		magnitude_pkg::edge_result_t e;
		int ax;
		int ay;
		int m;
		ax = (x < 0) ? -x : x;
		ay = (y < 0) ? -y : y;
		m = int_sqrt(x * x + y * y);
		e.valid = 1'b1;
		e.magnitude = out_prec'(m);
		e.edge_flag = (m >= level);
		// a tie between the axes counts as horizontal
		if (ax >= ay)
		begin
			e.direction = (x >= 0) ? magnitude_pkg::dir_east : magnitude_pkg::dir_west;
		end
		else
		begin
			e.direction = (y >= 0) ? magnitude_pkg::dir_north : magnitude_pkg::dir_south;
		end
		return e;
	endfunction

	task automatic report_counts();
		$display("errors: %0d value, %0d order, %0d latency", value_errors, order_errors,
			timing_errors);
	endtask

	// inputs change on the falling edge, the DUT takes them on the next rising edge
	task automatic drive_sample(input logic v, input logic signed [vec_w-1:0] x,
		input logic signed [vec_w-1:0] y, input logic en);
		@(negedge clk);
		clken = en;
		sample.valid = v;
		sample.x = x;
		sample.y = y;
		if (v && en)
		begin
			expected_q.push_back(expected_result(int'(x), int'(y), int'(threshold)));
			stamp_q.push_back(en_count);
		end
	endtask

	task automatic drive_random(input logic v, input logic en);
		rng = xorshift32(rng);
		drive_sample(v, $signed(rng[vec_w-1:0]), $signed(rng[2*vec_w-1:vec_w]), en);
	endtask

	// idle enabled cycles until every expected result came out
	// the two extra cycles clear a valid result still held at the output
	task automatic drain();
		drive_sample(1'b0, '0, '0, 1'b1);
		while (expected_q.size() != 0)
		begin
			drive_sample(1'b0, '0, '0, 1'b1);
		end
		repeat (2) drive_sample(1'b0, '0, '0, 1'b1);
	endtask

	task automatic sweep_at(input int level);
		threshold = out_prec'(level);
		for (int i = 0; i < sweep_n; i++)
		begin
			drive_sample(1'b1, sweep_x[i], sweep_y[i], 1'b1);
		end
		drain();
	endtask

	// edge count and timeout, clken is stable here since it moves on the falling edge
	always @(posedge clk)
	begin
		advanced = clken && !aclr;
		if (advanced)
		begin
			en_count++;
		end
		cycle_count++;
		if (cycle_count >= max_cycles)
		begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			report_counts();
			$display("sim failed");
			$finish;
		end
	end

	// a new result exists only after an enabled edge, it is checked on the falling edge
	always @(negedge clk)
	begin : compare
		magnitude_pkg::edge_result_t exp;
		int stamp;
		if (advanced && result.valid)
		begin
			if (expected_q.size() == 0)
			begin
				$display("a valid result came out at %0t with no sample in flight", $time);
				order_errors++;
			end
			else
			begin
				exp = expected_q.pop_front();
				stamp = stamp_q.pop_front();
				if (result !== exp)
				begin
					$display("error at %0t: mag/edge/dir %0d/%0b/%0d, expected %0d/%0b/%0d",
						$time, result.magnitude, result.edge_flag, result.direction,
						exp.magnitude, exp.edge_flag, exp.direction);
					value_errors++;
				end
				if (en_count - stamp != latency)
				begin
					$display("error at %0t: result after %0d enabled cycles, expected %0d",
						$time, en_count - stamp, latency);
					timing_errors++;
				end
			end
		end
	end

	initial
	begin
		aclr = 1'b0;
		clken = 1'b0;
		sample = '0;
		threshold = out_prec'(200);
		#1 aclr = 1'b1;
		repeat (16) @(posedge clk);
		@(negedge clk);
		if (result !== '0)
		begin
			$display("error at %0t: result is %h during reset", $time, result);
			value_errors++;
		end
		aclr = 1'b0;

		// idle enabled cycles after reset must leave every field at zero
		repeat (20)
		begin
			drive_sample(1'b0, '0, '0, 1'b1);
			if (result !== '0)
			begin
				$display("error at %0t: result is %h before any valid input", $time, result);
				value_errors++;
			end
		end

		// corners, 9'h100 is the most negative component
		drive_sample(1'b1, 9'sd0, 9'sd0, 1'b1);
		drive_sample(1'b1, 9'sd255, 9'sd0, 1'b1);
		drive_sample(1'b1, 9'h100, 9'h100, 1'b1);
		drive_sample(1'b1, 9'h100, 9'sd255, 1'b1);
		drive_sample(1'b1, 9'sd1, 9'sd1, 1'b1);
		drain();

		for (int i = 0; i < stream_n; i++)
		begin
			drive_random(1'b1, 1'b1);
		end
		drain();

		// clken is low on roughly one cycle in three
		for (int i = 0; i < stall_n; i++)
		begin
			rng = xorshift32(rng);
			drive_random(1'b1, (rng % 3) != 0);
		end
		drain();

		for (int i = 0; i < gap_n; i++)
		begin
			rng = xorshift32(rng);
			drive_random(rng[7], 1'b1);
		end
		drain();

		// one fixed set of samples, replayed against three threshold levels
		for (int i = 0; i < sweep_n; i++)
		begin
			rng = xorshift32(rng);
			sweep_x[i] = $signed(rng[vec_w-1:0]);
			sweep_y[i] = $signed(rng[2*vec_w-1:vec_w]);
		end
		sweep_at(0);
		sweep_at(128);
		sweep_at(1023);

		if (expected_q.size() != 0)
		begin
			$display("%0d expected results never came out", expected_q.size());
			order_errors++;
		end
		report_counts();
		if (value_errors + order_errors + timing_errors == 0)
		begin
			$display("sim passed");
		end
		else
		begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- tb.f
verilog/magnitude_pkg.sv
verilog/sum_of_squares.sv
verilog/root_pipeline.sv
verilog/magnitude.sv
verilog/edge_classifier.sv
verilog/gradient_magnitude_top.sv
verif/gradient_magnitude_properties.sv
verif/gradient_magnitude_tb.sv

//--- Makefile
TOP = gradient_magnitude_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -Wno-fatal -f tb.f --top-module $(TOP)

# the log decides the result, the exit status of the model is not used
run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "sim passed" $(LOG) || (echo "run ended without a result, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
